/* design/merge_pkg.sv */
package merge_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sizes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int KEY_W = 32;
   localparam int IN_FIFO_DEPTH = 16;
   localparam int OUT_FIFO_DEPTH = 16;

   // free output entries needed before a new command goes out
   // covers the command register, the pair register and the new command
   localparam int OUT_HEADROOM = 3;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [KEY_W-1:0] key_t; // zero is the end-of-list marker

   // lane 0 holds the smaller key in sorted data
   typedef struct packed {
      key_t lane1;
      key_t lane0;
   } tuple_t;

   typedef enum logic [1:0] {
      OP_PRIME = 2'd0, // load the held pair, no output
      OP_MERGE = 2'd1, // merge the held pair with a new tuple
      OP_FLUSH = 2'd2, // emit the held pair
      OP_TERM  = 2'd3  // emit the zero terminator
   } merge_op_t;

   // control to split stage
   typedef struct packed {
      logic      valid;
      merge_op_t op;
      tuple_t    data;
   } merge_cmd_t;

   // split stage to sort stage, lanes may arrive unordered
   typedef struct packed {
      logic   valid;
      tuple_t data;
   } pair_t;

endpackage

/* design/tuple_fifo.sv */
`timescale 1ns/100ps

module tuple_fifo #(
   parameter int DEPTH = 16
) (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_wr,
   input  merge_pkg::tuple_t i_data,
   input  logic              i_rd,
   output merge_pkg::tuple_t o_data,
   output logic              o_empty,
   output logic              o_full,
   output logic              o_almost_full
);

   localparam int AW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH + 1);

   merge_pkg::tuple_t mem [DEPTH];
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic [CW-1:0]     count;
   logic              wr_en;
   logic              rd_en;

   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign wr_en = i_wr & ~o_full;
   assign rd_en = i_rd & ~o_empty;

   always_ff @(posedge i_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign o_data  = mem[rd_ptr]; // show-ahead, head is visible without a read
   assign o_empty = (count == '0);
   assign o_full  = (count == CW'(DEPTH));

   assign o_almost_full = (CW'(DEPTH) - count) < CW'(merge_pkg::OUT_HEADROOM);

   // an overflow here means the writer ignored the flags it was given
   a_no_overflow : assert property (@(posedge i_clk) disable iff (i_rst)
      i_wr |-> !o_full);

   a_no_underflow : assert property (@(posedge i_clk) disable iff (i_rst)
      i_rd |-> !o_empty);

endmodule

/* design/merge_control.sv */
`timescale 1ns/100ps

module merge_control (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  merge_pkg::tuple_t     i_head_a,
   input  merge_pkg::tuple_t     i_head_b,
   input  logic                  i_empty_a,
   input  logic                  i_empty_b,
   input  logic                  i_out_almost_full,
   output logic                  o_pop_a,
   output logic                  o_pop_b,
   output merge_pkg::merge_cmd_t o_cmd
);

   typedef enum logic [1:0] {
      IDLE  = 2'd0, // waiting for the first tuple of a list pair
      RUN   = 2'd1,
      FLUSH = 2'd2,
      TERM  = 2'd3
   } state_t;

   state_t                state;
   state_t                state_next;
   merge_pkg::merge_cmd_t cmd_next;
   merge_pkg::tuple_t     picked;
   logic                  heads_ok;
   logic                  a_done;
   logic                  b_done;
   logic                  both_done;
   logic                  pick_a;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // selection
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign heads_ok  = ~i_empty_a & ~i_empty_b; // both heads must be known to compare
   assign a_done    = (i_head_a.lane0 == '0);
   assign b_done    = (i_head_b.lane0 == '0);
   assign both_done = a_done & b_done;

   // ties go to stream A
   assign pick_a = ~a_done & (b_done | (i_head_a.lane0 <= i_head_b.lane0));
   assign picked = pick_a ? i_head_a : i_head_b;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sequencing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      o_pop_a    = 1'b0;
      o_pop_b    = 1'b0;
      state_next = state;
      cmd_next   = '0;
      case (state)
         IDLE: begin
            if (heads_ok && both_done) begin
               state_next = TERM; // two empty lists, nothing held to flush
            end else if (heads_ok && !i_out_almost_full) begin
               o_pop_a        = pick_a;
               o_pop_b        = ~pick_a;
               cmd_next.valid = 1'b1;
               cmd_next.op    = merge_pkg::OP_PRIME;
               cmd_next.data  = picked;
               state_next     = RUN;
            end
         end
         RUN: begin
            if (heads_ok && both_done) begin
               state_next = FLUSH;
            end else if (heads_ok && !i_out_almost_full) begin
               o_pop_a        = pick_a;
               o_pop_b        = ~pick_a;
               cmd_next.valid = 1'b1;
               cmd_next.op    = merge_pkg::OP_MERGE;
               cmd_next.data  = picked;
            end
         end
         FLUSH: begin
            if (!i_out_almost_full) begin
               cmd_next.valid = 1'b1;
               cmd_next.op    = merge_pkg::OP_FLUSH;
               state_next     = TERM;
            end
         end
         TERM: begin
            if (heads_ok && !i_out_almost_full) begin
               o_pop_a        = 1'b1; // both terminators leave together
               o_pop_b        = 1'b1;
               cmd_next.valid = 1'b1;
               cmd_next.op    = merge_pkg::OP_TERM;
               state_next     = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state       <= IDLE;
         o_cmd.valid <= 1'b0;
      end else begin
         state       <= state_next;
         o_cmd.valid <= cmd_next.valid;
      end
   end

   always_ff @(posedge i_clk) begin
      o_cmd.op   <= cmd_next.op;
      o_cmd.data <= cmd_next.data;
   end

   // a double pop may only drop the two end markers
   a_single_pop : assert property (@(posedge i_clk) disable iff (i_rst)
      (o_pop_a && o_pop_b) |-> (i_head_a == '0 && i_head_b == '0));

endmodule

/* design/bitonic_split_stage.sv */
`timescale 1ns/100ps

module bitonic_split_stage (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  merge_pkg::merge_cmd_t i_cmd,
   output merge_pkg::pair_t      o_pair
);

   merge_pkg::tuple_t held; // upper pair kept back from the previous merge
   merge_pkg::tuple_t lower;
   merge_pkg::tuple_t upper;
   merge_pkg::key_t   lo0;
   merge_pkg::key_t   hi0;
   merge_pkg::key_t   lo1;
   merge_pkg::key_t   hi1;

   // held lane0, held lane1, new lane1, new lane0 is bitonic,
   // so one rank of cross compares splits it into lower and upper halves
   always_comb begin
      if (i_cmd.data.lane0 <= held.lane1) begin
         lo0 = i_cmd.data.lane0;
         hi0 = held.lane1;
      end else begin
         lo0 = held.lane1;
         hi0 = i_cmd.data.lane0;
      end
      if (i_cmd.data.lane1 <= held.lane0) begin
         lo1 = i_cmd.data.lane1;
         hi1 = held.lane0;
      end else begin
         lo1 = held.lane0;
         hi1 = i_cmd.data.lane1;
      end
      lower.lane0 = lo0; // left unordered, the sort stage finishes it
      lower.lane1 = lo1;
      upper.lane0 = (hi0 <= hi1) ? hi0 : hi1;
      upper.lane1 = (hi0 <= hi1) ? hi1 : hi0;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         held         <= '0;
         o_pair.valid <= 1'b0;
      end else begin
         o_pair.valid <= i_cmd.valid && (i_cmd.op != merge_pkg::OP_PRIME);
         if (i_cmd.valid) begin
            case (i_cmd.op)
               merge_pkg::OP_PRIME: held <= i_cmd.data;
               merge_pkg::OP_MERGE: held <= upper;
               merge_pkg::OP_FLUSH: held <= '0;
               default:             held <= held;
            endcase
         end
      end
   end

   always_ff @(posedge i_clk) begin
      case (i_cmd.op)
         merge_pkg::OP_MERGE: o_pair.data <= lower;
         merge_pkg::OP_FLUSH: o_pair.data <= held;
         default:             o_pair.data <= '0; // terminator
      endcase
   end

endmodule

/* design/pair_sort_stage.sv */
`timescale 1ns/100ps

module pair_sort_stage (
   input  logic              i_clk,
   input  logic              i_rst,
   input  merge_pkg::pair_t  i_pair,
   output logic              o_wr,
   output merge_pkg::tuple_t o_data
);

   merge_pkg::key_t last_key; // top key written so far in the current list

   // the pair register upstream feeds this swap, the output FIFO stores it
   always_comb begin
      o_wr = i_pair.valid;
      if (i_pair.data.lane0 <= i_pair.data.lane1) begin
         o_data = i_pair.data; // a zero tuple always lands here unchanged
      end else begin
         o_data.lane0 = i_pair.data.lane1;
         o_data.lane1 = i_pair.data.lane0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         last_key <= '0;
      end else if (o_wr) begin
         last_key <= o_data.lane1; // the terminator brings it back to zero
      end
   end

   // lanes in order and the stream never steps back within a list
   a_sorted_out : assert property (@(posedge i_clk) disable iff (i_rst)
      (o_wr && o_data != '0) |->
         (o_data.lane0 <= o_data.lane1 && last_key <= o_data.lane0));

endmodule

/* design/merger_top.sv */
`timescale 1ns/100ps

module merger_top (
   input  logic              i_clk,
   input  logic              i_rst,
   input  merge_pkg::tuple_t i_in_a,
   input  merge_pkg::tuple_t i_in_b,
   input  logic              i_in_a_empty,
   input  logic              i_in_b_empty,
   input  logic              i_out_ready,
   output logic              o_in_a_read,
   output logic              o_in_b_read,
   output logic              o_out_write,
   output merge_pkg::tuple_t o_out_data
);

   merge_pkg::tuple_t     head_a;
   merge_pkg::tuple_t     head_b;
   logic                  empty_a;
   logic                  empty_b;
   logic                  full_a;
   logic                  full_b;
   logic                  pop_a;
   logic                  pop_b;
   logic                  out_empty;
   logic                  out_almost_full;
   merge_pkg::merge_cmd_t cmd;
   merge_pkg::pair_t      pair;
   logic                  sort_wr;
   merge_pkg::tuple_t     sort_data;

   // upstream pops on the same edge that our FIFO takes the tuple
   assign o_in_a_read = ~i_in_a_empty & ~full_a;
   assign o_in_b_read = ~i_in_b_empty & ~full_b;
   assign o_out_write = i_out_ready & ~out_empty;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // input side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   tuple_fifo #(.DEPTH(merge_pkg::IN_FIFO_DEPTH)) u_fifo_a (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_wr          (o_in_a_read),
      .i_data        (i_in_a),
      .i_rd          (pop_a),
      .o_data        (head_a),
      .o_empty       (empty_a),
      .o_full        (full_a),
      .o_almost_full ()
   );

   tuple_fifo #(.DEPTH(merge_pkg::IN_FIFO_DEPTH)) u_fifo_b (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_wr          (o_in_b_read),
      .i_data        (i_in_b),
      .i_rd          (pop_b),
      .o_data        (head_b),
      .o_empty       (empty_b),
      .o_full        (full_b),
      .o_almost_full ()
   );

   merge_control u_control (
      .i_clk             (i_clk),
      .i_rst             (i_rst),
      .i_head_a          (head_a),
      .i_head_b          (head_b),
      .i_empty_a         (empty_a),
      .i_empty_b         (empty_b),
      .i_out_almost_full (out_almost_full),
      .o_pop_a           (pop_a),
      .o_pop_b           (pop_b),
      .o_cmd             (cmd)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // network and output side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   bitonic_split_stage u_split (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_cmd  (cmd),
      .o_pair (pair)
   );

   pair_sort_stage u_sort (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_pair (pair),
      .o_wr   (sort_wr),
      .o_data (sort_data)
   );

   tuple_fifo #(.DEPTH(merge_pkg::OUT_FIFO_DEPTH)) u_fifo_out (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_wr          (sort_wr),
      .i_data        (sort_data),
      .i_rd          (o_out_write),
      .o_data        (o_out_data),
      .o_empty       (out_empty),
      .o_full        (),
      .o_almost_full (out_almost_full)
   );

endmodule

/* verif/tb_merger_top.sv */
`timescale 1ns/100ps

module tb_merger_top;

   typedef merge_pkg::key_t key_q_t[$];

   // input tuples of all tests, terminators included
   localparam int TUPLE_TOTAL = 10 + 26 + 8 + 62 + 30;
   localparam int CYCLE_LIMIT = TUPLE_TOTAL * 10;

   logic              i_clk;
   logic              i_rst = 1'b1;
   merge_pkg::tuple_t i_in_a = '0;
   merge_pkg::tuple_t i_in_b = '0;
   logic              i_in_a_empty = 1'b1;
   logic              i_in_b_empty = 1'b1;
   logic              i_out_ready = 1'b0;
   logic              o_in_a_read;
   logic              o_in_b_read;
   logic              o_out_write;
   merge_pkg::tuple_t o_out_data;

   merge_pkg::tuple_t q_a[$]; // upstream FIFO models
   merge_pkg::tuple_t q_b[$];
   merge_pkg::tuple_t exp_q[$];
   logic              take_a = 1'b0;
   logic              take_b = 1'b0;
   logic              stall_on = 1'b0;
   int                errors = 0;
   int                drain_errors = 0;
   int                checks = 0;
   int                cycles = 0;
   int                tests = 0;

   merger_top i_merger_top (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_in_a       (i_in_a),
      .i_in_b       (i_in_b),
      .i_in_a_empty (i_in_a_empty),
      .i_in_b_empty (i_in_b_empty),
      .i_out_ready  (i_out_ready),
      .o_in_a_read  (o_in_a_read),
      .o_in_b_read  (o_in_b_read),
      .o_out_write  (o_out_write),
      .o_out_data   (o_out_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stream models and monitor
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // upstream pops on the edge that followed a high read strobe
   always @(posedge i_clk) begin
      #1;
      if (take_a) begin
         void'(q_a.pop_front());
      end
      if (take_b) begin
         void'(q_b.pop_front());
      end
      i_in_a_empty = (q_a.size() == 0);
      i_in_b_empty = (q_b.size() == 0);
      if (q_a.size() != 0) begin
         i_in_a = q_a[0];
      end else begin
         i_in_a = '0;
      end
      if (q_b.size() != 0) begin
         i_in_b = q_b[0];
      end else begin
         i_in_b = '0;
      end
      i_out_ready = stall_on ? ($urandom_range(3, 0) == 0) : 1'b1; // about one in four
   end

   // strobes and output are settled half a cycle after the inputs move
   always @(negedge i_clk) begin
      take_a = !i_rst && o_in_a_read;
      take_b = !i_rst && o_in_b_read;
      assert (!(take_a && i_in_a_empty) && !(take_b && i_in_b_empty)) else begin
         $display("ERROR at %0t: read strobe high while the upstream FIFO was empty",
                  $time);
         errors = errors + 1;
      end
      if (!i_rst && o_out_write) begin
         assert (i_out_ready) else begin
            $display("ERROR at %0t: o_out_write high while i_out_ready was low", $time);
            errors = errors + 1;
         end
         check_output(o_out_data);
      end
   end

   always @(posedge i_clk) begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Result: FAILED");
         $finish;
      end
   end

   function automatic merge_pkg::tuple_t make_tuple(input merge_pkg::key_t lo,
                                                    input merge_pkg::key_t hi);
      merge_pkg::tuple_t t;
      t.lane0 = lo;
      t.lane1 = hi;
      return t;
   endfunction

   // sorted list of nonzero keys, small range so ties are common
   function automatic key_q_t random_keys(input int n_tuples);
      key_q_t k;
      for (int i = 0; i < 2 * n_tuples; i++) begin
         k.push_back(merge_pkg::key_t'($urandom_range(500, 1)));
      end
      k.sort();
      return k;
   endfunction

   task automatic send_lists(input key_q_t ka, input key_q_t kb);
      key_q_t all;
      all = ka;
      foreach (kb[i]) begin
         all.push_back(kb[i]);
      end
      all.sort(); // reference merge is a plain sort of both lists
      for (int i = 0; i < ka.size(); i += 2) begin
         q_a.push_back(make_tuple(ka[i], ka[i+1]));
      end
      for (int i = 0; i < kb.size(); i += 2) begin
         q_b.push_back(make_tuple(kb[i], kb[i+1]));
      end
      q_a.push_back('0);
      q_b.push_back('0);
      for (int i = 0; i < all.size(); i += 2) begin
         exp_q.push_back(make_tuple(all[i], all[i+1]));
      end
      exp_q.push_back('0);
   endtask

   task automatic check_output(input merge_pkg::tuple_t got);
      merge_pkg::tuple_t want;
      checks = checks + 1;
      assert (exp_q.size() != 0) else begin
         $display("ERROR at %0t: output tuple %h written when none was expected",
                  $time, got);
         errors = errors + 1;
      end
      if (exp_q.size() != 0) begin
         want = exp_q.pop_front();
         assert (got == want) else begin
            $display("CHECK FAILED time %0t o_out_data expected %h actual %h",
                     $time, want, got);
            errors = errors + 1;
         end
      end
   endtask

   task automatic finish_test(input string name, input int err_base);
      while (exp_q.size() != 0) begin
         @(posedge i_clk);
      end
      repeat (5) @(posedge i_clk); // a duplicate tuple would show up here
      assert (q_a.size() == 0 && q_b.size() == 0) else begin
         $display("ERROR at %0t: %s left input tuples that were never read", $time, name);
         drain_errors = drain_errors + 1;
      end
      tests = tests + 1;
      $display("test %s done, %0d errors", name, errors + drain_errors - err_base);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic merge_interleaved();
      key_q_t ka;
      key_q_t kb;
      int     base;
      base = errors + drain_errors;
      for (int i = 1; i <= 8; i++) begin
         ka.push_back(merge_pkg::key_t'(2 * i - 1));
         kb.push_back(merge_pkg::key_t'(2 * i));
      end
      send_lists(ka, kb);
      finish_test("interleaved", base);
   endtask

   task automatic uneven_lengths();
      key_q_t none;
      int     base;
      base = errors + drain_errors;
      send_lists(random_keys(12), none);
      send_lists(random_keys(1), random_keys(7));
      send_lists(none, none); // terminator only on both sides
      finish_test("uneven lengths", base);
   endtask

   task automatic equal_keys();
      key_q_t ka;
      key_q_t kb;
      int     base;
      base = errors + drain_errors;
      ka = '{5, 5, 7, 9, 9, 12};
      kb = '{5, 7, 9, 9, 12, 12};
      send_lists(ka, kb);
      finish_test("equal keys", base);
   endtask

   // long enough that both input FIFOs fill while the output stalls
   task automatic output_stall();
      int base;
      base = errors + drain_errors;
      stall_on = 1'b1;
      send_lists(random_keys(30), random_keys(30));
      finish_test("output back-pressure", base);
      stall_on = 1'b0;
   endtask

   task automatic lists_back_to_back();
      int base;
      base = errors + drain_errors;
      send_lists(random_keys(5), random_keys(3));
      send_lists(random_keys(2), random_keys(6));
      send_lists(random_keys(4), random_keys(4));
      finish_test("back to back", base);
   endtask

   initial begin
      void'($urandom(32'h1c61));
      repeat (10) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      merge_interleaved();
      uneven_lengths();
      equal_keys();
      output_stall();
      lists_back_to_back();
      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors + drain_errors);
      if (errors + drain_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
design/merge_pkg.sv
design/tuple_fifo.sv
design/merge_control.sv
design/bitonic_split_stage.sv
design/pair_sort_stage.sv
design/merger_top.sv
verif/tb_merger_top.sv

/* Makefile */
SIM = obj_dir/Vtb_merger_top
SRCS = $(shell cat sources.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Result: PASSED" sim.log

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_merger_top \
		--Mdir obj_dir -o Vtb_merger_top

clean:
	rm -rf obj_dir sim.log
